//--- Bender.yml
package:
  name: cache_conf_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_conf_pkg.sv
      - hdl/ref_axis_bound.sv
      - hdl/axis_conf_stage.sv
      - hdl/cache_conf_stage.sv
  - target: test
    include_dirs:
      - hdl
      - verification
    files:
      - verification/tb_cache_conf_stage.sv

//--- cache_conf_stage.f
+incdir+hdl
+incdir+verification
hdl/cache_conf_pkg.sv
hdl/ref_axis_bound.sv
hdl/axis_conf_stage.sv
hdl/cache_conf_stage.sv
verification/tb_cache_conf_stage.sv

//--- hdl/axis_conf_stage.sv
`timescale 1ns/1ps

`include "cache_conf_config.svh"

`default_nettype none

module axis_conf_stage (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     load,
   input  cache_conf_pkg::pos_t     pic_dim,
   input  cache_conf_pkg::frac_t    frac,
   input  cache_conf_pkg::pos_t     luma_start,
   input  cache_conf_pkg::pos_t     chma_start,
   input  cache_conf_pkg::dim_t     luma_size,
   input  cache_conf_pkg::dim_t     chma_size,
   output cache_conf_pkg::addr_t    start_luma,
   output cache_conf_pkg::addr_ch_t start_chma,
   output cache_conf_pkg::dim_t     size_luma,
   output cache_conf_pkg::dim_ch_t  size_chma,
   output cache_conf_pkg::addr_t    great_start,
   output cache_conf_pkg::dim_t     great_size,
   output cache_conf_pkg::dim_t     offset_luma,
   output cache_conf_pkg::dim_t     end_luma,
   output cache_conf_pkg::dim_ch_t  offset_chma,
   output cache_conf_pkg::dim_ch_t  end_chma,
   output cache_conf_pkg::pos_t     luma_ref_start,
   output cache_conf_pkg::pos_t     chma_ref_start,
   output cache_conf_pkg::dim_t     luma_ref_size,
   output cache_conf_pkg::dim_t     chma_ref_size,
   output cache_conf_pkg::frac_t    frac_out
);

   cache_conf_pkg::addr_t    l_clamp;
   cache_conf_pkg::dim_t     l_size;
   cache_conf_pkg::dim_t     l_offset;
   cache_conf_pkg::dim_t     l_end;

   cache_conf_pkg::addr_t    c_clamp;      // full resolution, for the great window
   cache_conf_pkg::addr_ch_t c_clamp_sub;
   cache_conf_pkg::dim_t     c_size;       // unshifted
   cache_conf_pkg::dim_t     c_size_sub;
   cache_conf_pkg::dim_t     c_offset;
   cache_conf_pkg::dim_t     c_end;

   logic                     great_chma;

   // ----------------------------------------------------------------------
   // per component bounds
   // ----------------------------------------------------------------------
   ref_axis_bound #(
      .SUB_SHIFT (0),
      .BLK_MAX   (`CC_LUMA_BLK_MAX)
   ) u_luma_bound (
      .ref_start       (luma_start),
      .ref_size        (luma_size),
      .pic_dim         (pic_dim),
      .clamp_start     (l_clamp),
      .clamp_start_sub (),         // same as clamp_start for luma
      .fetch_size      (l_size),
      .fetch_size_sub  (),
      .blk_offset      (l_offset),
      .blk_end         (l_end)
   );

   ref_axis_bound #(
      .SUB_SHIFT (`CC_C_SUB_SHIFT),
      .BLK_MAX   (`CC_CHMA_BLK_MAX)
   ) u_chma_bound (
      .ref_start       (chma_start),
      .ref_size        (chma_size),
      .pic_dim         (pic_dim),
      .clamp_start     (c_clamp),
      .clamp_start_sub (c_clamp_sub),
      .fetch_size      (c_size),
      .fetch_size_sub  (c_size_sub),
      .blk_offset      (c_offset),
      .blk_end         (c_end)
   );

   // half-pel chroma needs the wider chroma window
   assign great_chma = (frac == `CC_FRAC_HALF);

   // ----------------------------------------------------------------------
   // output registers, loaded once per accepted block
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (load) begin
         start_luma  <= l_clamp;
         size_luma   <= l_size;
         offset_luma <= l_offset;
         end_luma    <= l_end;

         start_chma  <= c_clamp_sub;
         size_chma   <= c_size_sub[`CC_CHMA_DIM_WDTH-1:0];
         offset_chma <= c_offset[`CC_CHMA_DIM_WDTH-1:0];
         end_chma    <= c_end[`CC_CHMA_DIM_WDTH-1:0];

         luma_ref_start <= luma_start;
         luma_ref_size  <= luma_size;
         chma_ref_start <= chma_start >>> `CC_C_SUB_SHIFT;   // chroma units
         chma_ref_size  <= chma_size >> `CC_C_SUB_SHIFT;
         frac_out       <= frac;

         great_start <= great_chma ? c_clamp : l_clamp;
         great_size  <= great_chma ? c_size : l_size;
      end
   end

   // clamped luma start always addresses a sample inside the picture
   a_start_in_pic: assert property (
      @(posedge clk) disable iff (reset)
      load |=> ({1'b0, start_luma} < $past(pic_dim))
   ) else $error("axis_conf_stage: start_luma %0d outside picture", start_luma);

endmodule

`default_nettype wire

//--- hdl/cache_conf_config.svh
`ifndef CACHE_CONF_CONFIG_SVH
`define CACHE_CONF_CONFIG_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define CC_POS_WDTH        13    // signed picture coordinate / picture dim
`define CC_ADDR_WDTH       12    // clamped luma start
`define CC_DIM_WDTH        4     // luma size, offset, end
`define CC_CHMA_DIM_WDTH   3     // chroma size, offset, end
`define CC_FRAC_WDTH       3
`define CC_REF_IDX_WDTH    4

// ----------------------------------------------------------------------
// reference block geometry
// ----------------------------------------------------------------------
// span of the fetched reference block, 8 taps + block edge in luma
`define CC_LUMA_BLK_MAX    11
`define CC_CHMA_BLK_MAX    5

// 4:2:0 only, same shift in both axes
`define CC_C_SUB_SHIFT     1

// chroma fraction code for half-pel
`define CC_FRAC_HALF       3'b100

`endif

//--- hdl/cache_conf_pkg.sv
`default_nettype none

`include "cache_conf_config.svh"

package cache_conf_pkg;

   // signed start position, picture dimension, chroma start in chroma units
   typedef logic signed [`CC_POS_WDTH-1:0] pos_t;

   // clamped start addresses
   typedef logic [`CC_ADDR_WDTH-1:0] addr_t;
   typedef logic [`CC_ADDR_WDTH-`CC_C_SUB_SHIFT-1:0] addr_ch_t;   // after subsampling

   // block dimensions inside the reference block
   typedef logic [`CC_DIM_WDTH-1:0] dim_t;
   typedef logic [`CC_CHMA_DIM_WDTH-1:0] dim_ch_t;

   // side fields
   typedef logic [`CC_FRAC_WDTH-1:0] frac_t;
   typedef logic [`CC_REF_IDX_WDTH-1:0] ref_idx_t;

endpackage

`default_nettype wire

//--- hdl/cache_conf_stage.sv
`timescale 1ns/1ps

`default_nettype none

module cache_conf_stage (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     valid_in,
   input  logic                     tag_compare_stage_ready,
   input  cache_conf_pkg::pos_t     pic_width,
   input  cache_conf_pkg::pos_t     pic_height,
   input  cache_conf_pkg::ref_idx_t ref_idx_in_in,
   input  cache_conf_pkg::frac_t    ch_frac_x,
   input  cache_conf_pkg::frac_t    ch_frac_y,
   input  cache_conf_pkg::pos_t     luma_ref_start_x_in,
   input  cache_conf_pkg::pos_t     luma_ref_start_y_in,
   input  cache_conf_pkg::pos_t     chma_ref_start_x_in,
   input  cache_conf_pkg::pos_t     chma_ref_start_y_in,
   input  cache_conf_pkg::dim_t     luma_ref_width_x_in,
   input  cache_conf_pkg::dim_t     luma_ref_height_y_in,
   input  cache_conf_pkg::dim_t     chma_ref_width_x_in,
   input  cache_conf_pkg::dim_t     chma_ref_height_y_in,

   output logic                     op_conf_fifo_wr_en,
   output cache_conf_pkg::ref_idx_t ref_idx_in,
   output cache_conf_pkg::addr_t    start_x_in,
   output cache_conf_pkg::addr_t    start_y_in,
   output cache_conf_pkg::addr_ch_t start_x_ch,
   output cache_conf_pkg::addr_ch_t start_y_ch,
   output cache_conf_pkg::dim_t     rf_blk_wdt_in,
   output cache_conf_pkg::dim_t     rf_blk_hgt_in,
   output cache_conf_pkg::dim_ch_t  rf_blk_wdt_ch,
   output cache_conf_pkg::dim_ch_t  rf_blk_hgt_ch,
   output cache_conf_pkg::addr_t    start_great_x_in,
   output cache_conf_pkg::addr_t    start_great_y_in,
   output cache_conf_pkg::dim_t     rf_blk_great_wdt_in,
   output cache_conf_pkg::dim_t     rf_blk_great_hgt_in,
   output cache_conf_pkg::dim_t     d_block_x_offset_luma,
   output cache_conf_pkg::dim_t     d_block_y_offset_luma,
   output cache_conf_pkg::dim_t     d_block_x_end_luma,
   output cache_conf_pkg::dim_t     d_block_y_end_luma,
   output cache_conf_pkg::dim_ch_t  d_block_x_offset_chma,
   output cache_conf_pkg::dim_ch_t  d_block_y_offset_chma,
   output cache_conf_pkg::dim_ch_t  d_block_x_end_chma,
   output cache_conf_pkg::dim_ch_t  d_block_y_end_chma,
   output cache_conf_pkg::pos_t     luma_ref_start_x,
   output cache_conf_pkg::pos_t     luma_ref_start_y,
   output cache_conf_pkg::pos_t     chma_ref_start_x,
   output cache_conf_pkg::pos_t     chma_ref_start_y,
   output cache_conf_pkg::dim_t     luma_ref_width_x,
   output cache_conf_pkg::dim_t     luma_ref_height_y,
   output cache_conf_pkg::dim_t     chma_ref_width_x,
   output cache_conf_pkg::dim_t     chma_ref_height_y,
   output cache_conf_pkg::frac_t    d_frac_x_out,
   output cache_conf_pkg::frac_t    d_frac_y_out
);

   logic accept;

   // no hold on back-pressure, the source keeps its block
   assign accept = valid_in & tag_compare_stage_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         op_conf_fifo_wr_en <= 1'b0;
         ref_idx_in         <= '0;
      end else begin
         op_conf_fifo_wr_en <= accept;   // one strobe per accept
         if (accept) begin
            ref_idx_in <= ref_idx_in_in;
         end
      end
   end

   // ----------------------------------------------------------------------
   // x and y are independent
   // ----------------------------------------------------------------------
   axis_conf_stage axis_x (
      .clk            (clk),
      .reset          (reset),
      .load           (accept),
      .pic_dim        (pic_width),
      .frac           (ch_frac_x),
      .luma_start     (luma_ref_start_x_in),
      .chma_start     (chma_ref_start_x_in),
      .luma_size      (luma_ref_width_x_in),
      .chma_size      (chma_ref_width_x_in),
      .start_luma     (start_x_in),
      .start_chma     (start_x_ch),
      .size_luma      (rf_blk_wdt_in),
      .size_chma      (rf_blk_wdt_ch),
      .great_start    (start_great_x_in),
      .great_size     (rf_blk_great_wdt_in),
      .offset_luma    (d_block_x_offset_luma),
      .end_luma       (d_block_x_end_luma),
      .offset_chma    (d_block_x_offset_chma),
      .end_chma       (d_block_x_end_chma),
      .luma_ref_start (luma_ref_start_x),
      .chma_ref_start (chma_ref_start_x),
      .luma_ref_size  (luma_ref_width_x),
      .chma_ref_size  (chma_ref_width_x),
      .frac_out       (d_frac_x_out)
   );

   axis_conf_stage axis_y (
      .clk            (clk),
      .reset          (reset),
      .load           (accept),
      .pic_dim        (pic_height),
      .frac           (ch_frac_y),
      .luma_start     (luma_ref_start_y_in),
      .chma_start     (chma_ref_start_y_in),
      .luma_size      (luma_ref_height_y_in),
      .chma_size      (chma_ref_height_y_in),
      .start_luma     (start_y_in),
      .start_chma     (start_y_ch),
      .size_luma      (rf_blk_hgt_in),
      .size_chma      (rf_blk_hgt_ch),
      .great_start    (start_great_y_in),
      .great_size     (rf_blk_great_hgt_in),
      .offset_luma    (d_block_y_offset_luma),
      .end_luma       (d_block_y_end_luma),
      .offset_chma    (d_block_y_offset_chma),
      .end_chma       (d_block_y_end_chma),
      .luma_ref_start (luma_ref_start_y),
      .chma_ref_start (chma_ref_start_y),
      .luma_ref_size  (luma_ref_height_y),
      .chma_ref_size  (chma_ref_height_y),
      .frac_out       (d_frac_y_out)
   );

   // strobe only follows an accepted block
   a_strobe_after_accept: assert property (
      @(posedge clk) disable iff (reset)
      op_conf_fifo_wr_en |-> $past(accept)
   ) else $error("cache_conf_stage: fifo write without accept");

endmodule

`default_nettype wire

//--- hdl/ref_axis_bound.sv
`timescale 1ns/1ps

`include "cache_conf_config.svh"

`default_nettype none

module ref_axis_bound #(
   parameter int SUB_SHIFT = 0,   // 0 for luma, 1 for subsampled chroma
   parameter int BLK_MAX   = 11
) (
   input  cache_conf_pkg::pos_t     ref_start,
   input  cache_conf_pkg::dim_t     ref_size,
   input  cache_conf_pkg::pos_t     pic_dim,
   output cache_conf_pkg::addr_t    clamp_start,
   output cache_conf_pkg::addr_ch_t clamp_start_sub,
   output cache_conf_pkg::dim_t     fetch_size,
   output cache_conf_pkg::dim_t     fetch_size_sub,
   output cache_conf_pkg::dim_t     blk_offset,
   output cache_conf_pkg::dim_t     blk_end
);

   localparam int SUB_ADDR_W = $bits(cache_conf_pkg::addr_ch_t);
   localparam cache_conf_pkg::dim_t BLK_LAST = cache_conf_pkg::dim_t'(BLK_MAX - 1);

   cache_conf_pkg::pos_t size_ext;
   cache_conf_pkg::pos_t ref_end;        // first position past the block
   cache_conf_pkg::pos_t pic_last;
   cache_conf_pkg::pos_t pic_last_sub;
   cache_conf_pkg::pos_t start_sub;
   cache_conf_pkg::pos_t lead_dist;      // samples hanging off the low edge
   cache_conf_pkg::pos_t rem;            // samples left up to the high edge
   cache_conf_pkg::dim_t end_low;
   cache_conf_pkg::dim_t lead_low;
   cache_conf_pkg::dim_t rem_low;
   logic                 neg_start;
   logic                 neg_end;

   initial begin
      assert (BLK_MAX - 1 < (1 << `CC_DIM_WDTH))
         else $error("ref_axis_bound: BLK_MAX %0d too large for dim_t", BLK_MAX);
   end

   // ----------------------------------------------------------------------
   // edge distances
   // ----------------------------------------------------------------------
   assign size_ext     = cache_conf_pkg::pos_t'(ref_size);   // zero extended
   assign ref_end      = ref_start + size_ext;
   assign pic_last     = pic_dim - cache_conf_pkg::pos_t'(1);
   assign pic_last_sub = (pic_dim >>> SUB_SHIFT) - cache_conf_pkg::pos_t'(1);
   assign start_sub    = ref_start >>> SUB_SHIFT;
   assign lead_dist    = -ref_start;
   assign rem          = pic_last - ref_start;

   assign neg_start = ref_start[`CC_POS_WDTH-1];
   assign neg_end   = ref_end[`CC_POS_WDTH-1];

   // all of these fit a block dimension whenever they are used
   assign end_low  = ref_end[`CC_DIM_WDTH-1:0];
   assign lead_low = lead_dist[`CC_DIM_WDTH-1:0];
   assign rem_low  = rem[`CC_DIM_WDTH-1:0];

   // ----------------------------------------------------------------------
   // start clamp
   // ----------------------------------------------------------------------
   always_comb begin
      if (neg_start) begin
         clamp_start     = '0;
         clamp_start_sub = '0;
      end else if (ref_start >= pic_dim) begin
         clamp_start     = pic_last[`CC_ADDR_WDTH-1:0];
         clamp_start_sub = pic_last_sub[SUB_ADDR_W-1:0];
      end else begin
         clamp_start     = ref_start[`CC_ADDR_WDTH-1:0];
         clamp_start_sub = start_sub[SUB_ADDR_W-1:0];
      end
   end

   // ----------------------------------------------------------------------
   // fetch size, offset and end inside the reference block
   // ----------------------------------------------------------------------
   always_comb begin
      if (neg_start) begin
         blk_end = BLK_LAST;
         if (neg_end) begin   // nothing of the block lies inside the picture
            blk_offset     = BLK_LAST;
            fetch_size     = '0;
            fetch_size_sub = '0;
         end else begin
            fetch_size     = end_low;
            fetch_size_sub = end_low >> SUB_SHIFT;
            blk_offset     = lead_low >> SUB_SHIFT;
         end
      end else if (ref_end >= pic_dim) begin
         blk_offset = '0;
         if (rem[`CC_POS_WDTH-1]) begin   // start already past the edge
            fetch_size     = '0;
            fetch_size_sub = '0;
            blk_end        = '0;
         end else begin
            fetch_size     = rem_low;
            fetch_size_sub = rem_low >> SUB_SHIFT;
            blk_end        = rem_low >> SUB_SHIFT;
         end
      end else begin
         fetch_size     = ref_size;
         fetch_size_sub = ref_size >> SUB_SHIFT;
         blk_offset     = '0;
         blk_end        = ref_size >> SUB_SHIFT;
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_conf_model.svh
`ifndef TB_CONF_MODEL_SVH
`define TB_CONF_MODEL_SVH

// ----------------------------------------------------------------------
// expected axis word is bounds then great window then pass fields
// ----------------------------------------------------------------------
localparam int BOUND_W = 44;
localparam int GREAT_W = 16;
localparam int PASS_W  = 37;
localparam int AXIS_W  = BOUND_W + GREAT_W + PASS_W;

// one axis of one component, k is the subsampling shift
function automatic void bound_model(
   input  int s,
   input  int w,
   input  int p,
   input  int k,
   input  int blk,
   output int clamp,
   output int clamp_sub,
   output int size,
   output int size_sub,
   output int offset,
   output int end_pos
);
   int e;
   e = s + w;
   clamp     = (s < 0) ? 0 : (s >= p) ? p - 1 : s;
   clamp_sub = (s < 0) ? 0 : (s >= p) ? (p >> k) - 1 : s >> k;
   if (s < 0) begin
      end_pos  = blk - 1;
      offset   = (e < 0) ? blk - 1 : (-s) >> k;
      size     = (e < 0) ? 0 : e;
      size_sub = size >> k;
   end else if (e >= p) begin
      offset   = 0;
      size     = (p - 1 - s < 0) ? 0 : p - 1 - s;   // nothing left past the edge
      size_sub = size >> k;
      end_pos  = size_sub;
   end else begin
      offset   = 0;
      size     = w;
      size_sub = w >> k;
      end_pos  = size_sub;
   end
endfunction

function automatic logic [AXIS_W-1:0] axis_model(input int p, input int frac, input int ls,
                                                 input int lw, input int cs, input int cw);
   int lc, lcs, lsz, lszs, lo, le;
   int cc, ccs, csz, cszs, co, ce;
   logic [BOUND_W-1:0] bound;
   logic [GREAT_W-1:0] great;
   logic [PASS_W-1:0]  pass;
   bound_model(ls, lw, p, 0, `CC_LUMA_BLK_MAX, lc, lcs, lsz, lszs, lo, le);
   bound_model(cs, cw, p, `CC_C_SUB_SHIFT, `CC_CHMA_BLK_MAX, cc, ccs, csz, cszs, co, ce);
   bound = {cache_conf_pkg::addr_t'(lc), cache_conf_pkg::addr_ch_t'(ccs),
            cache_conf_pkg::dim_t'(lsz), cache_conf_pkg::dim_ch_t'(cszs),
            cache_conf_pkg::dim_t'(lo), cache_conf_pkg::dim_t'(le),
            cache_conf_pkg::dim_ch_t'(co), cache_conf_pkg::dim_ch_t'(ce)};
   if (frac == `CC_FRAC_HALF)   // half-pel takes the chroma window
      great = {cache_conf_pkg::addr_t'(cc), cache_conf_pkg::dim_t'(csz)};
   else
      great = {cache_conf_pkg::addr_t'(lc), cache_conf_pkg::dim_t'(lsz)};
   pass = {cache_conf_pkg::pos_t'(ls), cache_conf_pkg::pos_t'(cs >>> `CC_C_SUB_SHIFT),
           cache_conf_pkg::dim_t'(lw), cache_conf_pkg::dim_t'(cw >> `CC_C_SUB_SHIFT),
           cache_conf_pkg::frac_t'(frac)};
   return {bound, great, pass};
endfunction

// ----------------------------------------------------------------------
// random blocks around the picture edges
// ----------------------------------------------------------------------
function automatic int pick_in_range(input int lo, input int hi);
   bit [31:0] r;
   r = $random(seed);
   return lo + int'(r % (hi - lo + 1));
endfunction

task automatic random_block();
   int pw;
   int ph;
   pw = pick_in_range(16, 1024);
   ph = pick_in_range(16, 1024);
   pic_width  = cache_conf_pkg::pos_t'(pw);
   pic_height = cache_conf_pkg::pos_t'(ph);
   set_x(pick_in_range(-24, pw + 8), pick_in_range(0, 15), pick_in_range(-24, pw + 8),
         pick_in_range(0, 15), pick_in_range(0, 7));
   set_y(pick_in_range(-24, ph + 8), pick_in_range(0, 15), pick_in_range(-24, ph + 8),
         pick_in_range(0, 15), pick_in_range(0, 7));
endtask

`endif

//--- verification/tb_cache_conf_stage.sv
`timescale 1ns/1ps

`default_nettype none

`include "cache_conf_config.svh"

module tb_cache_conf_stage;

   localparam int TIMEOUT = 20;   // cycles

   logic clk;
   logic reset;
   logic valid_in;
   logic tag_compare_stage_ready;
   logic op_conf_fifo_wr_en;
   cache_conf_pkg::pos_t     pic_width, pic_height;
   cache_conf_pkg::ref_idx_t ref_idx_in_in, ref_idx_in;
   cache_conf_pkg::frac_t    ch_frac_x, ch_frac_y, d_frac_x_out, d_frac_y_out;
   cache_conf_pkg::pos_t     luma_ref_start_x_in, luma_ref_start_y_in;
   cache_conf_pkg::pos_t     chma_ref_start_x_in, chma_ref_start_y_in;
   cache_conf_pkg::dim_t     luma_ref_width_x_in, luma_ref_height_y_in;
   cache_conf_pkg::dim_t     chma_ref_width_x_in, chma_ref_height_y_in;
   cache_conf_pkg::addr_t    start_x_in, start_y_in, start_great_x_in, start_great_y_in;
   cache_conf_pkg::addr_ch_t start_x_ch, start_y_ch;
   cache_conf_pkg::dim_t     rf_blk_wdt_in, rf_blk_hgt_in;
   cache_conf_pkg::dim_t     rf_blk_great_wdt_in, rf_blk_great_hgt_in;
   cache_conf_pkg::dim_ch_t  rf_blk_wdt_ch, rf_blk_hgt_ch;
   cache_conf_pkg::dim_t     d_block_x_offset_luma, d_block_y_offset_luma;
   cache_conf_pkg::dim_t     d_block_x_end_luma, d_block_y_end_luma;
   cache_conf_pkg::dim_ch_t  d_block_x_offset_chma, d_block_y_offset_chma;
   cache_conf_pkg::dim_ch_t  d_block_x_end_chma, d_block_y_end_chma;
   cache_conf_pkg::pos_t     luma_ref_start_x, luma_ref_start_y;
   cache_conf_pkg::pos_t     chma_ref_start_x, chma_ref_start_y;
   cache_conf_pkg::dim_t     luma_ref_width_x, luma_ref_height_y;
   cache_conf_pkg::dim_t     chma_ref_width_x, chma_ref_height_y;

   int    check_errors = 0;
   int    timeouts = 0;
   int    seed = 32'h23d05dcb;
   string test_name = "reset";
   string chk_name = "reset";   // name of the block under check

   `include "tb_conf_model.svh"

   logic [AXIS_W-1:0]        act_x, act_y, exp_x, exp_y;
   logic                     exp_wr_en;
   logic                     exp_valid;
   cache_conf_pkg::ref_idx_t exp_ref_idx;

   cache_conf_stage uut (.*);

   assign act_x = {start_x_in, start_x_ch, rf_blk_wdt_in, rf_blk_wdt_ch, d_block_x_offset_luma,
                   d_block_x_end_luma, d_block_x_offset_chma, d_block_x_end_chma,
                   start_great_x_in, rf_blk_great_wdt_in, luma_ref_start_x, chma_ref_start_x,
                   luma_ref_width_x, chma_ref_width_x, d_frac_x_out};
   assign act_y = {start_y_in, start_y_ch, rf_blk_hgt_in, rf_blk_hgt_ch, d_block_y_offset_luma,
                   d_block_y_end_luma, d_block_y_offset_chma, d_block_y_end_chma,
                   start_great_y_in, rf_blk_great_hgt_in, luma_ref_start_y, chma_ref_start_y,
                   luma_ref_height_y, chma_ref_height_y, d_frac_y_out};

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // expected values captured at each accept
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      if (reset) begin
         exp_wr_en   <= 1'b0;
         exp_valid   <= 1'b0;
         exp_ref_idx <= '0;
      end else begin
         exp_wr_en <= valid_in & tag_compare_stage_ready;
         if (valid_in && tag_compare_stage_ready) begin
            exp_x <= axis_model(int'(pic_width), int'(ch_frac_x), int'(luma_ref_start_x_in),
                                int'(luma_ref_width_x_in), int'(chma_ref_start_x_in),
                                int'(chma_ref_width_x_in));
            exp_y <= axis_model(int'(pic_height), int'(ch_frac_y), int'(luma_ref_start_y_in),
                                int'(luma_ref_height_y_in), int'(chma_ref_start_y_in),
                                int'(chma_ref_height_y_in));
            exp_ref_idx <= ref_idx_in_in;
            exp_valid   <= 1'b1;
            chk_name    <= test_name;
         end
      end
   end

   task automatic report_mismatch(input string what, input logic [127:0] expv,
                                  input logic [127:0] actv);
      check_errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", chk_name, what, expv, actv);
   endtask

   strobe_check: assert property (@(posedge clk) disable iff (reset)
      op_conf_fifo_wr_en == exp_wr_en)
      else report_mismatch("fifo write strobe", $sampled(exp_wr_en), $sampled(op_conf_fifo_wr_en));
   ref_idx_check: assert property (@(posedge clk) disable iff (reset)
      ref_idx_in == exp_ref_idx)
      else report_mismatch("ref_idx", $sampled(exp_ref_idx), $sampled(ref_idx_in));

   // outputs hold between accepts
   x_bound_check: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> act_x[AXIS_W-1 -: BOUND_W] == exp_x[AXIS_W-1 -: BOUND_W])
      else report_mismatch("x bounds", $sampled(exp_x[AXIS_W-1 -: BOUND_W]),
                           $sampled(act_x[AXIS_W-1 -: BOUND_W]));
   y_bound_check: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> act_y[AXIS_W-1 -: BOUND_W] == exp_y[AXIS_W-1 -: BOUND_W])
      else report_mismatch("y bounds", $sampled(exp_y[AXIS_W-1 -: BOUND_W]),
                           $sampled(act_y[AXIS_W-1 -: BOUND_W]));
   x_great_check: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> act_x[PASS_W +: GREAT_W] == exp_x[PASS_W +: GREAT_W])
      else report_mismatch("x great window", $sampled(exp_x[PASS_W +: GREAT_W]),
                           $sampled(act_x[PASS_W +: GREAT_W]));
   y_great_check: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> act_y[PASS_W +: GREAT_W] == exp_y[PASS_W +: GREAT_W])
      else report_mismatch("y great window", $sampled(exp_y[PASS_W +: GREAT_W]),
                           $sampled(act_y[PASS_W +: GREAT_W]));
   x_pass_check: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> act_x[PASS_W-1:0] == exp_x[PASS_W-1:0])
      else report_mismatch("x pass fields", $sampled(exp_x[PASS_W-1:0]),
                           $sampled(act_x[PASS_W-1:0]));
   y_pass_check: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> act_y[PASS_W-1:0] == exp_y[PASS_W-1:0])
      else report_mismatch("y pass fields", $sampled(exp_y[PASS_W-1:0]),
                           $sampled(act_y[PASS_W-1:0]));

   // ----------------------------------------------------------------------
   // stimulus tasks for the falling edge
   // ----------------------------------------------------------------------
   task automatic set_x(input int ls, input int lw, input int cs, input int cw, input int fr);
      luma_ref_start_x_in = cache_conf_pkg::pos_t'(ls);
      luma_ref_width_x_in = cache_conf_pkg::dim_t'(lw);
      chma_ref_start_x_in = cache_conf_pkg::pos_t'(cs);
      chma_ref_width_x_in = cache_conf_pkg::dim_t'(cw);
      ch_frac_x           = cache_conf_pkg::frac_t'(fr);
   endtask

   task automatic set_y(input int ls, input int lw, input int cs, input int cw, input int fr);
      luma_ref_start_y_in  = cache_conf_pkg::pos_t'(ls);
      luma_ref_height_y_in = cache_conf_pkg::dim_t'(lw);
      chma_ref_start_y_in  = cache_conf_pkg::pos_t'(cs);
      chma_ref_height_y_in = cache_conf_pkg::dim_t'(cw);
      ch_frac_y            = cache_conf_pkg::frac_t'(fr);
   endtask

   task automatic wait_strobe(input string name);
      int cycles;
      cycles = 0;
      while (!op_conf_fifo_wr_en && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!op_conf_fifo_wr_en) begin
         $display("timeout: no FIFO write strobe for block %s", name);
         timeouts++;
      end
   endtask

   // returns on the falling edge with the strobe up
   task automatic send_block(input string name);
      int cycles;
      test_name     = name;
      ref_idx_in_in = ref_idx_in_in + 1'b1;
      valid_in      = 1'b1;
      cycles        = 0;
      @(posedge clk);
      while (!tag_compare_stage_ready && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      @(negedge clk);
      valid_in = 1'b0;
      if (cycles >= TIMEOUT) begin
         $display("timeout: block %s was never accepted", name);
         timeouts++;
      end else begin
         wait_strobe(name);
      end
   endtask

   task automatic idle(input int n);
      valid_in = 1'b0;
      repeat (n) @(negedge clk);
   endtask

   initial begin
      reset                   = 1'b1;
      valid_in                = 1'b0;
      tag_compare_stage_ready = 1'b1;
      pic_width               = 13'sd64;
      pic_height              = 13'sd48;
      ref_idx_in_in           = '0;
      set_x(0, 0, 0, 0, 0);
      set_y(0, 0, 0, 0, 0);
      repeat (2) @(negedge clk);
      reset = 1'b0;
      idle(2);

      set_x(20, 11, 20, 5, 0);
      set_y(10, 11, 10, 5, 1);
      send_block("inside");
      idle(1);
      set_x(-3, 11, -4, 6, 2);
      set_y(-15, 11, -10, 5, 0);   // y block fully above the picture
      send_block("left_above");
      set_x(-20, 11, -9, 8, 0);
      set_y(-2, 7, -3, 6, 5);
      send_block("outside_left_top_edge");
      set_x(60, 11, 61, 6, 0);
      set_y(45, 8, 44, 7, 3);
      send_block("right_bottom_edge");
      set_x(70, 11, 66, 6, 1);
      set_y(48, 5, 50, 4, 0);
      send_block("beyond_right_bottom");
      idle(1);

      // great window choice with both and mixed half-pel axes
      set_x(-3, 11, 61, 6, `CC_FRAC_HALF);
      set_y(45, 8, -4, 7, `CC_FRAC_HALF);
      send_block("half_pel_both");
      set_y(40, 11, 30, 6, 2);
      send_block("half_pel_x_only");
      set_x(30, 9, 28, 7, 3);
      set_y(-1, 11, 47, 5, `CC_FRAC_HALF);
      send_block("half_pel_y_only");

      // back-pressure holds the last block
      set_x(5, 4, 6, 3, 0);
      set_y(6, 5, 7, 2, 0);
      ref_idx_in_in           = ref_idx_in_in + 1'b1;
      test_name               = "stall";
      tag_compare_stage_ready = 1'b0;
      valid_in                = 1'b1;
      repeat (5) @(negedge clk);
      tag_compare_stage_ready = 1'b1;
      send_block("stall_release");
      idle(1);

      for (int i = 0; i < 200; i++) begin
         random_block();
         send_block($sformatf("random_%0d", i));
         if (pick_in_range(0, 1) == 1) begin
            idle(1);
         end
      end
      idle(3);

      $display("errors: %0d check, %0d timeout", check_errors, timeouts);
      if (check_errors == 0 && timeouts == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
